/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_simmem
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+verilog
verilog/simmem_axi_pkg.sv
verilog/simmem_bank_pkg.sv
verilog/simmem_rsv_if.sv
verilog/simmem_delay_calc.sv
verilog/simmem_rsp_bank.sv
verilog/simmem_top.sv
testbench/tb_clkgen.sv
testbench/tb_simmem.sv

/* testbench/simmem_tests.txt */
# name id burst_len resp mem_delay bp
# burst_len is beats minus one, mem_delay in cycles, bp 1 means random output ready
fill_a0   0  0  0  40  0
fill_a1   1  3  1  42  0
fill_a2   2  1  2  44  0
fill_a3   3  7  3  46  0
fill_a4   0  2  1  30  0
fill_a5   1  0  0  20  0
fill_a6   2  5  3  10  0
fill_a7   3  1  2   5  0
full_a8   0  4  0   3  0
full_a9   1  1  1   8  0
ooo_b0    2 15  1  35  0
ooo_b1    3  0  2   2  0
ooo_b2    2  0  0   1  0
ooo_b3    0  9  3  12  0
bp_c0     1  2  0   4  1
bp_c1     1  0  3   6  1
bp_c2     3  6  1  15  1
bp_c3     0  1  2   3  1
bp_c4     2  0  0   0  1
bp_c5     1 31  3  20  1

/* testbench/tb_clkgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PeriodNs = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

endmodule

/* testbench/tb_simmem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the simulated memory write path
// Replays the test table, models the memory and checks per-ID order,
// minimum latency and output hold under back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "simmem_macros.svh"

module tb_simmem
  import simmem_axi_pkg::*;
();

  localparam int PeriodNs = 100;

  logic   clk;
  logic   rst_i;
  logic   waddr_in_valid_i, waddr_out_ready_i, waddr_in_ready_o, waddr_out_valid_o;
  logic   wrsp_in_valid_i, wrsp_out_ready_i, wrsp_in_ready_o, wrsp_out_valid_o;
  waddr_t waddr_i, waddr_o;
  wrsp_t  wrsp_i, wrsp_o;

  // Test table as read from the file
  string t_name[$];
  int    t_id[$], t_len[$], t_rsp[$], t_dly[$], t_bp[$];
  // Expected responses in address accept order
  string sb_name[$];
  int    sb_id[$], sb_rsp[$], sb_min[$];
  // Memory model, responses not yet returned
  int    pm_id[$], pm_rsp[$], pm_due[$];

  int          cyc, ti, n_done, mem_idx, limit_cycles, err_value, err_other;
  logic        mem_busy, bp_mode, saw_full, prev_valid, prev_ready;
  logic        tests_loaded = 1'b0;
  wrsp_t       prev_rsp;
  logic [31:0] lfsr_q;

  tb_clkgen #(.PeriodNs(PeriodNs)) clkgen0 (.clk_o(clk));

  simmem_top dut0 (
    .clk_i            (clk),
    .rst_i            (rst_i),
    .waddr_in_valid_i (waddr_in_valid_i),
    .waddr_out_ready_i(waddr_out_ready_i),
    .waddr_in_ready_o (waddr_in_ready_o),
    .waddr_out_valid_o(waddr_out_valid_o),
    .wrsp_in_valid_i  (wrsp_in_valid_i),
    .wrsp_out_ready_i (wrsp_out_ready_i),
    .wrsp_in_ready_o  (wrsp_in_ready_o),
    .wrsp_out_valid_o (wrsp_out_valid_o),
    .waddr_i          (waddr_i),
    .wrsp_i           (wrsp_i),
    .waddr_o          (waddr_o),
    .wrsp_o           (wrsp_o)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Base delay, one beat delay per beat, one cycle for the output register
  function automatic int min_latency(input int len);
    return `SIMMEM_BASE_DELAY + `SIMMEM_BEAT_DELAY * (len + 1) + 1;
  endfunction

  // Oldest outstanding entry of an ID, or -1
  function automatic int oldest_for_id(input int id);
    for (int k = 0; k < sb_id.size(); k++) begin
      if (sb_id[k] == id) return k;
    end
    return -1;
  endfunction

  task automatic load_tests();
    int    fd, n, id, len, rsp, dly, bp;
    string line, name;
    fd = $fopen("testbench/simmem_tests.txt", "r");
    if (fd == 0) begin
      err_other++;
      $display("Cannot open testbench/simmem_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %d %d %d %d %d", name, id, len, rsp, dly, bp);
        if (n == 6) begin
          t_name.push_back(name);
          t_id.push_back(id);
          t_len.push_back(len);
          t_rsp.push_back(rsp);
          t_dly.push_back(dly);
          t_bp.push_back(bp);
          limit_cycles += dly + min_latency(len) + 40;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_inputs();
    logic [`SIMMEM_NUM_IDS-1:0] seen;
    int                         sel;
    seen = '0;
    sel  = -1;
    // Downstream stalls one cycle in seven
    waddr_out_ready_i = (cyc % 7 != 3);
    waddr_in_valid_i  = (ti < t_id.size());
    if (ti < t_id.size()) begin
      waddr_i = '{id: axi_id_t'(t_id[ti]), addr: 32'h4000_0000 + 32'(ti) * 32'h40,
                  burst_len: axi_len_t'(t_len[ti])};
    end
    // Memory answers in order within an ID, freely across IDs
    if (!mem_busy) begin
      for (int k = 0; k < pm_id.size(); k++) begin
        if (sel < 0 && pm_due[k] <= cyc && !seen[pm_id[k]]) sel = k;
        seen[pm_id[k]] = 1'b1;
      end
      if (sel >= 0) begin
        mem_busy = 1'b1;
        mem_idx  = sel;
      end
    end
    wrsp_in_valid_i = mem_busy;
    if (mem_busy) begin
      wrsp_i = '{id: axi_id_t'(pm_id[mem_idx]), resp: axi_resp_t'(pm_rsp[mem_idx])};
    end
    if (bp_mode) begin
      lfsr_q = lfsr_step(lfsr_q);
      wrsp_out_ready_i = lfsr_q[0];
    end else begin
      wrsp_out_ready_i = 1'b1;
    end
  endtask

  // Runs between the falling edge and the next rising edge
  task automatic check_cycle();
    int    k;
    logic  has_slot, exp_addr_ready, exp_in_ready;
    string name;
    has_slot       = (sb_id.size() < `SIMMEM_BANK_CAPA);
    exp_addr_ready = waddr_out_ready_i && has_slot;
    exp_in_ready   = 1'b0;
    name     = (ti < t_name.size()) ? t_name[ti] : "idle";
    if (!has_slot) saw_full = 1'b1;
    // A slot waits for every address whose memory response is still due
    for (int m = 0; m < pm_id.size(); m++) begin
      if (pm_id[m] == int'(wrsp_i.id)) exp_in_ready = 1'b1;
    end
    assert (waddr_in_ready_o === exp_addr_ready) else begin
      err_value++;
      $display("ERR %s waddr_in_ready exp %0b act %0b", name, exp_addr_ready,
               waddr_in_ready_o);
    end
    assert (waddr_out_valid_o === (waddr_in_valid_i && has_slot)) else begin
      err_value++;
      $display("ERR %s waddr_out_valid exp %0b act %0b", name,
               waddr_in_valid_i && has_slot, waddr_out_valid_o);
    end
    assert (wrsp_in_ready_o === exp_in_ready) else begin
      err_value++;
      $display("ERR %s wrsp_in_ready exp %0b act %0b", name, exp_in_ready,
               wrsp_in_ready_o);
    end
    if (waddr_in_valid_i && waddr_in_ready_o) begin
      assert (waddr_o === waddr_i) else begin
        err_value++;
        $display("ERR %s waddr_o exp %h act %h", name, waddr_i, waddr_o);
      end
      sb_name.push_back(name);
      sb_id.push_back(t_id[ti]);
      sb_rsp.push_back(t_rsp[ti]);
      sb_min.push_back(cyc + min_latency(t_len[ti]));
      pm_id.push_back(t_id[ti]);
      pm_rsp.push_back(t_rsp[ti]);
      pm_due.push_back(cyc + t_dly[ti]);
      bp_mode = (t_bp[ti] != 0);
      ti++;
    end
    if (wrsp_in_valid_i && wrsp_in_ready_o) begin
      pm_id.delete(mem_idx);
      pm_rsp.delete(mem_idx);
      pm_due.delete(mem_idx);
      mem_busy = 1'b0;
    end
    if (prev_valid && !prev_ready) begin
      k = oldest_for_id(int'(prev_rsp.id));
      assert (wrsp_out_valid_o === 1'b1 && wrsp_o === prev_rsp) else begin
        err_value++;
        $display("ERR %s held response exp %h act %h valid %0b",
                 (k >= 0) ? sb_name[k] : "none", prev_rsp, wrsp_o, wrsp_out_valid_o);
      end
    end
    if (wrsp_out_valid_o && wrsp_out_ready_i) begin
      k = oldest_for_id(int'(wrsp_o.id));
      assert (k >= 0) else begin
        err_other++;
        $display("Response for ID %0d came out with nothing outstanding", wrsp_o.id);
      end
      if (k >= 0) begin
        assert (wrsp_o.resp === axi_resp_t'(sb_rsp[k])) else begin
          err_value++;
          $display("ERR %s resp exp %0d act %0d", sb_name[k], sb_rsp[k], wrsp_o.resp);
        end
        assert (cyc >= sb_min[k]) else begin
          err_value++;
          $display("ERR %s release cycle exp >= %0d act %0d", sb_name[k], sb_min[k], cyc);
        end
        sb_name.delete(k);
        sb_id.delete(k);
        sb_rsp.delete(k);
        sb_min.delete(k);
        n_done++;
      end
    end
    prev_valid = wrsp_out_valid_o;
    prev_ready = wrsp_out_ready_i;
    prev_rsp   = wrsp_o;
  endtask

  task automatic finish_run(input logic timed_out);
    if (timed_out) err_other++;
    $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin : main_seq
    rst_i             = 1'b1;
    waddr_in_valid_i  = 1'b0;
    waddr_out_ready_i = 1'b0;
    waddr_i           = '0;
    wrsp_in_valid_i   = 1'b0;
    wrsp_i            = '0;
    wrsp_out_ready_i  = 1'b0;
    lfsr_q            = 32'h090d_478d;
    {cyc, ti, n_done, mem_idx, err_value, err_other} = '0;
    {mem_busy, bp_mode, saw_full, prev_valid, prev_ready} = '0;
    prev_rsp     = '0;
    limit_cycles = 100;
    load_tests();
    tests_loaded = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    while (ti < t_id.size() || sb_id.size() > 0 || pm_id.size() > 0) begin
      @(negedge clk);
      drive_inputs();
      #(PeriodNs / 4);
      check_cycle();
      cyc++;
    end
    assert (t_id.size() > 0 && n_done == t_id.size()) else begin
      err_other++;
      $display("Only %0d of %0d responses came back", n_done, t_id.size());
    end
    assert (saw_full) else begin
      err_other++;
      $display("The response bank never filled up");
    end
    finish_run(1'b0);
  end

  initial begin : watchdog
    wait (tests_loaded === 1'b1);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d responses outstanding",
             limit_cycles, sb_id.size());
    finish_run(1'b1);
  end

endmodule

/* verilog/simmem_axi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus-side channel types of the simulated memory write path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "simmem_macros.svh"

package simmem_axi_pkg;

  typedef logic [$clog2(`SIMMEM_NUM_IDS)-1:0] axi_id_t;

  // Burst length, encoded as beats minus one
  typedef logic [7:0] axi_len_t;

  // OKAY, EXOKAY, SLVERR, DECERR
  typedef logic [1:0] axi_resp_t;

  // 42-bit write address word
  typedef struct packed {
    axi_id_t     id;
    logic [31:0] addr;
    axi_len_t    burst_len;
  } waddr_t;

  // 4-bit write response word
  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } wrsp_t;

endpackage

/* verilog/simmem_bank_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response bank types: slot index, slot masks and slot state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "simmem_macros.svh"

package simmem_bank_pkg;

  // Slot index, also wide enough for a slot age rank
  typedef logic [$clog2(`SIMMEM_BANK_CAPA)-1:0] iid_t;

  // One bit per slot
  typedef logic [`SIMMEM_BANK_CAPA-1:0] slot_mask_t;

  // DONE_WAIT means the response sits in the output register
  typedef enum logic [1:0] {
    FREE      = 2'd0,
    WAIT_RSP  = 2'd1,
    HELD      = 2'd2,
    DONE_WAIT = 2'd3
  } slot_state_e;

endpackage

/* verilog/simmem_delay_calc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write response delay calculator
// Reserves a bank slot per address and counts out its latency,
// then grants release of that slot to the response bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "simmem_macros.svh"

module simmem_delay_calc
  import simmem_axi_pkg::*, simmem_bank_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,

  input  waddr_t     waddr_i,
  input  logic       waddr_valid_i,
  output logic       waddr_ready_o,

  output slot_mask_t release_en_o,
  input  slot_mask_t released_i,

  simmem_rsv_if.requester rsv
);

  localparam int unsigned FullW = `SIMMEM_CNT_W + $bits(axi_len_t);

  logic [`SIMMEM_CNT_W-1:0] cnt_q [`SIMMEM_BANK_CAPA];
  slot_mask_t               active_q;

  logic                     rsv_fire;
  logic [FullW-1:0]         delay_full;
  logic [`SIMMEM_CNT_W-1:0] delay_ld;

  // Address requests go straight into the reservation link
  assign rsv.valid     = waddr_valid_i;
  assign rsv.id        = waddr_i.id;
  assign rsv.burst_len = waddr_i.burst_len;
  assign waddr_ready_o = rsv.ready;

  assign rsv_fire = rsv.valid & rsv.ready;

  // Base plus one beat delay per beat
  always_comb begin
    delay_full = FullW'(`SIMMEM_BASE_DELAY)
               + FullW'(`SIMMEM_BEAT_DELAY) * (FullW'(rsv.burst_len) + FullW'(1));
    // Saturate long bursts to the counter range
    if (delay_full > FullW'({`SIMMEM_CNT_W{1'b1}})) begin
      delay_ld = '1;
    end else begin
      delay_ld = delay_full[`SIMMEM_CNT_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= '0;
    end else begin
      for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
        if (rsv_fire && rsv.iid == iid_t'(i)) begin
          active_q[i] <= 1'b1;
        end else if (released_i[i]) begin
          active_q[i] <= 1'b0;
        end
      end
    end
  end

  // Latency countdown per slot
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
      if (rsv_fire && rsv.iid == iid_t'(i)) begin
        cnt_q[i] <= delay_ld;
      end else if (active_q[i] && cnt_q[i] != '0) begin
        cnt_q[i] <= cnt_q[i] - 1'b1;
      end
    end
  end

  // Expired and not yet taken by the bank
  always_comb begin
    for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
      release_en_o[i] = active_q[i] && (cnt_q[i] == '0);
    end
  end

  // The bank must only offer slots whose counter was handed back
  a_no_reload: assert property (@(posedge clk_i) disable iff (rst_i)
    rsv_fire |-> !active_q[rsv.iid]);

endmodule

/* verilog/simmem_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simulated memory controller sizing and latency macros
// Shared by the packages and the write response path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SIMMEM_MACROS_SVH
`define SIMMEM_MACROS_SVH

// Distinct AXI transaction IDs
`define SIMMEM_NUM_IDS 4

// Response slots in the bank
`define SIMMEM_BANK_CAPA 8

// Fixed part of the simulated latency, in cycles
`define SIMMEM_BASE_DELAY 6

// Added per burst beat
`define SIMMEM_BEAT_DELAY 2

// Width of each slot latency counter
`define SIMMEM_CNT_W 8

`endif

/* verilog/simmem_rsp_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write response bank
// Holds memory responses per slot and releases them in per-ID order
// through a registered requester-side response port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "simmem_macros.svh"

module simmem_rsp_bank
  import simmem_axi_pkg::*, simmem_bank_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,

  input  slot_mask_t release_en_i,
  output slot_mask_t released_o,

  input  wrsp_t      wrsp_i,
  input  logic       wrsp_in_valid_i,
  output logic       wrsp_in_ready_o,

  output wrsp_t      wrsp_o,
  output logic       wrsp_out_valid_o,
  input  logic       wrsp_out_ready_i,

  simmem_rsv_if.bank rsv
);

  slot_state_e state_q [`SIMMEM_BANK_CAPA];
  axi_id_t     id_q    [`SIMMEM_BANK_CAPA];
  axi_resp_t   resp_q  [`SIMMEM_BANK_CAPA];
  // Count of younger occupied slots, so larger means older
  iid_t        age_q   [`SIMMEM_BANK_CAPA];

  slot_mask_t free_mask, in_match, in_sel, eligible, rel_sel, older_than_out, done_mask;
  iid_t       rsv_iid, rel_iid;
  logic       rsv_fire, in_fire, out_fire, out_free;

  logic       out_valid_q;
  wrsp_t      out_rsp_q;
  iid_t       out_iid_q;

  assign rsv_fire = rsv.valid & rsv.ready;
  assign in_fire  = wrsp_in_valid_i & wrsp_in_ready_o;
  assign out_fire = out_valid_q & wrsp_out_ready_i;
  assign out_free = ~out_valid_q | wrsp_out_ready_i;

  always_comb begin
    rsv_iid = '0;
    rel_iid = '0;
    for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
      free_mask[i] = (state_q[i] == FREE);
      done_mask[i] = (state_q[i] == DONE_WAIT);
      in_match[i]  = (state_q[i] == WAIT_RSP) && (id_q[i] == wrsp_i.id);
      eligible[i]  = (state_q[i] == HELD) && release_en_i[i];
      older_than_out[i] = out_fire && (state_q[i] != FREE) && (age_q[i] > age_q[out_iid_q]);
    end
    for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
      in_sel[i] = in_match[i];
      for (int j = 0; j < `SIMMEM_BANK_CAPA; j++) begin
        // Memory answers oldest first within an ID
        if (in_match[j] && age_q[j] > age_q[i]) begin
          in_sel[i] = 1'b0;
        end
        // Older same-ID slot still pending blocks this one
        if ((state_q[j] == WAIT_RSP || state_q[j] == HELD) &&
            id_q[j] == id_q[i] && age_q[j] > age_q[i]) begin
          eligible[i] = 1'b0;
        end
      end
    end
    // Lowest index wins in both encoders
    for (int i = `SIMMEM_BANK_CAPA - 1; i >= 0; i--) begin
      if (free_mask[i]) rsv_iid = iid_t'(i);
      if (eligible[i]) rel_iid = iid_t'(i);
    end
    rel_sel = '0;
    if (out_free && |eligible) rel_sel[rel_iid] = 1'b1;
  end

  assign rsv.ready        = |free_mask;
  assign rsv.iid          = rsv_iid;
  assign wrsp_in_ready_o  = |in_match;
  assign released_o       = rel_sel;
  assign wrsp_o           = out_rsp_q;
  assign wrsp_out_valid_o = out_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
        state_q[i] <= FREE;
        age_q[i]   <= '0;
      end
      out_valid_q <= 1'b0;
    end else begin
      for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
        if (state_q[i] != FREE) begin
          if (rsv_fire && !older_than_out[i]) age_q[i] <= age_q[i] + 1'b1;
          else if (!rsv_fire && older_than_out[i]) age_q[i] <= age_q[i] - 1'b1;
        end
        unique case (state_q[i])
          FREE: if (rsv_fire && rsv_iid == iid_t'(i)) begin
            state_q[i] <= WAIT_RSP;
            age_q[i]   <= '0;
          end
          WAIT_RSP:  if (in_fire && in_sel[i]) state_q[i] <= HELD;
          HELD:      if (rel_sel[i]) state_q[i] <= DONE_WAIT;
          // Only the slot in the output register is here
          DONE_WAIT: if (out_fire) state_q[i] <= FREE;
        endcase
      end
      if (|rel_sel) out_valid_q <= 1'b1;
      else if (out_fire) out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsv_fire) id_q[rsv_iid] <= rsv.id;
    for (int i = 0; i < `SIMMEM_BANK_CAPA; i++) begin
      if (in_fire && in_sel[i]) resp_q[i] <= wrsp_i.resp;
    end
    if (|rel_sel) begin
      out_rsp_q <= '{id: id_q[rel_iid], resp: resp_q[rel_iid]};
      out_iid_q <= rel_iid;
    end
  end

  // Output register valid exactly while one released slot waits in it
  a_done_onehot0: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(done_mask) && (out_valid_q == |done_mask));

  // Exactly one waiting slot takes each accepted response
  a_rsp_has_slot: assert property (@(posedge clk_i) disable iff (rst_i)
    in_fire |-> $onehot(in_sel));

  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_q && !wrsp_out_ready_i |=> out_valid_q && $stable(out_rsp_q));

endmodule

/* verilog/simmem_rsv_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot reservation link from the delay calculator to the bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface simmem_rsv_if
  import simmem_axi_pkg::*, simmem_bank_pkg::*;
();

  logic     valid;
  // High while a slot is free
  logic     ready;
  axi_id_t  id;
  // Lowest free slot
  iid_t     iid;
  axi_len_t burst_len;

  modport requester (
    output valid, id, burst_len,
    input  ready, iid
  );

  // Latency is not the bank's concern, so no burst length here
  modport bank (
    input  valid, id,
    output ready, iid
  );

endinterface

/* verilog/simmem_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simulated memory controller, write path
// Passes write addresses through and delays write responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "simmem_macros.svh"

module simmem_top
  import simmem_axi_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,

  input  logic   waddr_in_valid_i,
  input  logic   waddr_out_ready_i,
  output logic   waddr_in_ready_o,
  output logic   waddr_out_valid_o,

  input  logic   wrsp_in_valid_i,
  input  logic   wrsp_out_ready_i,
  output logic   wrsp_in_ready_o,
  output logic   wrsp_out_valid_o,

  input  waddr_t waddr_i,
  input  wrsp_t  wrsp_i,

  output waddr_t waddr_o,
  output wrsp_t  wrsp_o
);

  simmem_rsv_if rsv ();

  logic                        waddr_valid_dc;
  logic                        waddr_ready_dc;
  logic [`SIMMEM_BANK_CAPA-1:0] release_en;
  logic [`SIMMEM_BANK_CAPA-1:0] released;

  // A reservation needs both a free slot and a ready downstream
  assign waddr_valid_dc    = waddr_in_valid_i & waddr_out_ready_i;
  assign waddr_in_ready_o  = waddr_out_ready_i & waddr_ready_dc;
  assign waddr_out_valid_o = waddr_in_valid_i & waddr_ready_dc;

  // Addresses are not modified
  assign waddr_o = waddr_i;

  simmem_delay_calc i_delay_calc (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .waddr_i      (waddr_i),
    .waddr_valid_i(waddr_valid_dc),
    .waddr_ready_o(waddr_ready_dc),
    .release_en_o (release_en),
    .released_i   (released),
    .rsv          (rsv.requester)
  );

  simmem_rsp_bank i_rsp_bank (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .release_en_i    (release_en),
    .released_o      (released),
    .wrsp_i          (wrsp_i),
    .wrsp_in_valid_i (wrsp_in_valid_i),
    .wrsp_in_ready_o (wrsp_in_ready_o),
    .wrsp_o          (wrsp_o),
    .wrsp_out_valid_o(wrsp_out_valid_o),
    .wrsp_out_ready_i(wrsp_out_ready_i),
    .rsv             (rsv.bank)
  );

endmodule
